// ==== vlog.f ====
+incdir+src
src/upsample_pkg.sv
src/sample_history.sv
src/halfband_preadd.sv
src/halfband_mac.sv
src/halfband_output.sv
src/upsample_top.sv
verif/upsample_tb.sv

// ==== Makefile ====
VERILATOR    ?= verilator
TOP          ?= upsample_tb
RTL_TOP      ?= upsample_top
FILELIST     ?= vlog.f
OBJ_DIR      ?= obj_dir
COMMON_FLAGS ?= --timing --timescale 1ns/1ps
LINT_FLAGS   ?= --lint-only
SIM_FLAGS    ?= --binary -j 0
PASS_MSG     := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Pass or fail is taken from the simulation output, no log is kept
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/upsample_tb.sv ====
`timescale 1ns/1ps
`include "upsample_macros.svh"

module upsample_tb;
    import upsample_pkg::*;

    localparam int pipe_latency = 4;
    localparam int reset_cycles = 4;
    localparam int flush_beats = 6;
    localparam int impulse_lead = 3;
    localparam int const_beats = 12;
    localparam int sat_beats = 10;
    localparam int rand_beats = 200;
    localparam int pre_reset_beats = 20;
    localparam int post_reset_beats = 30;

    // Beats over all tests, in the order they run
    localparam int total_beats = (reset_cycles + flush_beats)
                               + (impulse_lead + 1 + flush_beats)
                               + (const_beats + flush_beats)
                               + (sat_beats + flush_beats)
                               + (rand_beats + flush_beats)
                               + (pre_reset_beats + reset_cycles)
                               + (post_reset_beats + flush_beats);
    localparam int cycle_limit = total_beats + 50;

    localparam int sat_hi = (1 << (`UPS_SAMPLE_W-1)) - 1;
    localparam int sat_lo = -(1 << (`UPS_SAMPLE_W-1));

    bit        clk_i;
    logic      rst_n_i;
    in_beat_t  data_i;
    out_beat_t data_o;

    // Samples applied since the last reset, x[0] first
    sample_t   hist [$];
    // Observed output beats, keyed by beat number
    out_beat_t out_log [int];
    int        nb;
    int        beat_errors;
    int        sample_errors;
    int unsigned rng_state = 32'h81ce_264f;
    int unsigned cycle_count;
    string     current_test;

    upsample_top i_dut (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (data_i),
        .data_o  (data_o)
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        for (cycle_count = 0; cycle_count < cycle_limit; cycle_count++) begin
            @(posedge clk_i);
        end
        $display("Simulation timed out after %0d cycles", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic in_beat_t make_beat(input int s0, input int s1, input int s2, input int s3);
        in_beat_t b;
        b[0*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = sample_t'(s0);
        b[1*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = sample_t'(s1);
        b[2*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = sample_t'(s2);
        b[3*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = sample_t'(s3);
        return b;
    endfunction

    function automatic in_beat_t random_beat();
        in_beat_t b;
        int unsigned r;
        for (int i = 0; i < `UPS_LANES; i++) begin
            r = next_rand();
            // Upper bits of the generator are the better ones
            b[i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = r[31 -: `UPS_SAMPLE_W];
        end
        return b;
    endfunction

    function automatic sample_t lane_of(input out_beat_t b, input int lane);
        return sample_t'(b[lane*`UPS_SAMPLE_W +: `UPS_SAMPLE_W]);
    endfunction

    // Samples outside the recorded history are zero
    function automatic int sample_at(input int n);
        if (n < 0 || n >= hist.size()) begin
            return 0;
        end
        return int'(hist[n]);
    endfunction

    function automatic int coeff_of(input int j);
        case (j)
            0: return `UPS_C0;
            1: return `UPS_C1;
            2: return `UPS_C2;
            3: return `UPS_C3;
            default: return 0;
        endcase
    endfunction

    // Interpolated sample between x[k] and x[k+1]
    function automatic sample_t interp_at(input int k);
        int acc;
        acc = 0;
        for (int j = 0; j < 4; j++) begin
            acc = acc + coeff_of(j) * (sample_at(k - j) + sample_at(k + 1 + j));
        end
        acc = (acc + (1 << (`UPS_FRAC-1))) >>> `UPS_FRAC;
        if (acc > sat_hi) begin
            acc = sat_hi;
        end else if (acc < sat_lo) begin
            acc = sat_lo;
        end
        return sample_t'(acc);
    endfunction

    function automatic out_beat_t expected_beat(input int m);
        out_beat_t b;
        int k;
        b = '0;
        for (int i = 0; i < `UPS_LANES; i++) begin
            k = `UPS_LANES * m + i;
            b[2*i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = sample_t'(sample_at(k));
            b[(2*i+1)*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = interp_at(k);
        end
        return b;
    endfunction

    task automatic check_beat(input string test, input int m, input out_beat_t exp,
                              input out_beat_t act);
        if (act !== exp) begin
            beat_errors++;
            $display("Fail %s beat %0d: expected %h, actual %h", test, m, exp, act);
        end
    endtask

    task automatic check_sample(input string test, input int m, input int lane,
                                input sample_t exp, input sample_t act);
        if (act !== exp) begin
            sample_errors++;
            $display("Fail %s beat %0d lane %0d: expected %0d, actual %0d",
                     test, m, lane, exp, act);
        end
    endtask

    // Called at a falling edge; checks the output, drives one beat, waits one cycle
    task automatic step_beat(input in_beat_t beat);
        out_beat_t seen;
        int m;
        // Beat m shows up after edge e+4 and is read at the next falling edge
        m = nb - (pipe_latency + 1);
        seen = data_o;
        out_log[m] = seen;
        check_beat(current_test, m, expected_beat(m), seen);
        data_i = beat;
        for (int i = 0; i < `UPS_LANES; i++) begin
            hist.push_back(sample_t'(beat[i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W]));
        end
        nb++;
        @(negedge clk_i);
    endtask

    task automatic flush_zeros(input int count);
        for (int i = 0; i < count; i++) begin
            step_beat('0);
        end
    endtask

    // Output must stay zero while reset is low; history restarts on release
    task automatic hold_reset(input int cycles);
        rst_n_i = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            data_i = random_beat();
            @(negedge clk_i);
            check_beat(current_test, c, '0, data_o);
        end
        rst_n_i = 1'b1;
        data_i = '0;
        hist.delete();
        out_log.delete();
        nb = 0;
    endtask

    task automatic reset_state();
        current_test = "reset";
        hold_reset(reset_cycles);
        for (int i = 0; i < flush_beats; i++) begin
            check_beat(current_test, nb, '0, data_o);
            step_beat('0);
        end
    endtask

    task automatic impulse_response();
        int b0;
        int m;
        int lane;
        int odd_tab [8];
        current_test = "impulse";
        // Rounded coefficients mirrored around the impulse
        odd_tab = '{-11, 56, -157, 612, 612, -157, 56, -11};
        flush_zeros(impulse_lead);
        b0 = nb;
        step_beat(make_beat(1000, 0, 0, 0));
        flush_zeros(flush_beats);
        check_sample(current_test, b0, 0, sample_t'(1000), lane_of(out_log[b0], 0));
        for (int q = 0; q < 8; q++) begin
            m = b0 - 1 + q / 4;
            lane = 2 * (q % 4) + 1;
            check_sample(current_test, m, lane, sample_t'(odd_tab[q]),
                         lane_of(out_log[m], lane));
        end
    endtask

    task automatic constant_level();
        int c0;
        current_test = "constant";
        c0 = nb;
        for (int i = 0; i < const_beats; i++) begin
            step_beat(make_beat(500, 500, 500, 500));
        end
        flush_zeros(flush_beats);
        // Only beats whose whole window lies inside the run
        for (int m = c0 + 1; m <= c0 + const_beats - 2; m++) begin
            for (int lane = 0; lane < 2*`UPS_LANES; lane++) begin
                check_sample(current_test, m, lane, sample_t'(500), lane_of(out_log[m], lane));
            end
        end
    endtask

    task automatic saturation_limits();
        int s0;
        current_test = "saturation";
        s0 = nb;
        for (int i = 0; i < sat_beats; i++) begin
            step_beat(make_beat(sat_hi, sat_hi, sat_lo, sat_lo));
        end
        flush_zeros(flush_beats);
        // Overshoot between equal samples clamps at both rails
        for (int m = s0 + 1; m <= s0 + sat_beats - 2; m++) begin
            check_sample(current_test, m, 1, sample_t'(sat_hi), lane_of(out_log[m], 1));
            check_sample(current_test, m, 5, sample_t'(sat_lo), lane_of(out_log[m], 5));
        end
    endtask

    task automatic random_stream();
        current_test = "random";
        for (int i = 0; i < rand_beats; i++) begin
            step_beat(random_beat());
        end
        flush_zeros(flush_beats);
    endtask

    task automatic midstream_reset();
        current_test = "midstream_reset";
        for (int i = 0; i < pre_reset_beats; i++) begin
            step_beat(random_beat());
        end
        hold_reset(reset_cycles);
        for (int i = 0; i < post_reset_beats; i++) begin
            step_beat(random_beat());
        end
        flush_zeros(flush_beats);
    endtask

    initial begin
        rst_n_i = 1'b0;
        data_i = '0;
        reset_state();
        impulse_response();
        constant_level();
        saturation_limits();
        random_stream();
        midstream_reset();
        $display("Errors: %0d beat, %0d sample, %0d total",
                 beat_errors, sample_errors, beat_errors + sample_errors);
        if ((beat_errors + sample_errors) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== src/upsample_top.sv ====
`timescale 1ns/1ps

module upsample_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  upsample_pkg::in_beat_t   data_i,
    output upsample_pkg::out_beat_t  data_o
);
    import upsample_pkg::*;

    window_t  window;
    preadd_t  preadd;
    product_t product;

    // Window is combinational from the beat registers
    sample_history i_history (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .data_i   (data_i),
        .window_o (window)
    );

    halfband_preadd i_preadd (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .window_i (window),
        .preadd_o (preadd)
    );

    halfband_mac i_mac (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .preadd_i  (preadd),
        .product_o (product)
    );

    // Final stage interleaves and registers the output beat
    halfband_output i_output (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .product_i (product),
        .data_o    (data_o)
    );

endmodule

// ==== src/halfband_output.sv ====
`timescale 1ns/1ps
`include "upsample_macros.svh"

module halfband_output (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  upsample_pkg::product_t  product_i,
    output upsample_pkg::out_beat_t data_o
);
    import upsample_pkg::*;

    // Rounding constant and clamp limits
    localparam acc_t half_lsb = acc_t'(1) <<< (`UPS_FRAC-1);
    localparam acc_t sat_hi = acc_t'((1 << (`UPS_SAMPLE_W-1)) - 1);
    localparam acc_t sat_lo = -sat_hi - acc_t'(1);

    acc_t      acc [`UPS_LANES];
    acc_t      scaled [`UPS_LANES];
    sample_t   filt [`UPS_LANES];
    out_beat_t beat_d;
    out_beat_t beat_q;

    // Per-lane sum of the four weighted pairs
    always_comb begin
        for (int i = 0; i < `UPS_LANES; i++) begin
            acc[i] = '0;
            for (int j = 0; j < 4; j++) begin
                acc[i] = acc[i] + acc_t'(product_i.prod[i][j]);
            end
        end
    end

    // Round half up, drop the fraction, then clamp to the sample range
    always_comb begin
        for (int i = 0; i < `UPS_LANES; i++) begin
            scaled[i] = (acc[i] + half_lsb) >>> `UPS_FRAC;
            if (scaled[i] > sat_hi) begin
                filt[i] = sample_t'(sat_hi);
            end else if (scaled[i] < sat_lo) begin
                filt[i] = sample_t'(sat_lo);
            end else begin
                filt[i] = sample_t'(scaled[i]);
            end
        end
    end

    // Even output lanes take the input samples, odd lanes the interpolated ones
    always_comb begin
        beat_d = '0;
        for (int i = 0; i < `UPS_LANES; i++) begin
            beat_d[2*i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = product_i.centre[i];
            beat_d[(2*i+1)*`UPS_SAMPLE_W +: `UPS_SAMPLE_W] = filt[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            beat_q <= '0;
        end else begin
            beat_q <= beat_d;
        end
    end

    assign data_o = beat_q;

endmodule

// ==== src/halfband_mac.sv ====
`timescale 1ns/1ps
`include "upsample_macros.svh"

module halfband_mac (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  upsample_pkg::preadd_t   preadd_i,
    output upsample_pkg::product_t  product_o
);
    import upsample_pkg::*;

    // Entry j weights the pair j samples away from the centre
    localparam coeff_t [3:0] coeff_tab = {
        coeff_t'(`UPS_C3),
        coeff_t'(`UPS_C2),
        coeff_t'(`UPS_C1),
        coeff_t'(`UPS_C0)
    };

    product_t product_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            product_q <= '0;
        end else begin
            // Centre samples ride along to stay aligned with their lane
            product_q.centre <= preadd_i.centre;
            for (int i = 0; i < `UPS_LANES; i++) begin
                for (int j = 0; j < 4; j++) begin
                    product_q.prod[i][j] <= prod_t'(preadd_i.pair[i][j])
                                          * prod_t'(coeff_tab[j]);
                end
            end
        end
    end

    assign product_o = product_q;

endmodule

// ==== src/halfband_preadd.sv ====
`timescale 1ns/1ps
`include "upsample_macros.svh"

module halfband_preadd (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  upsample_pkg::window_t  window_i,
    output upsample_pkg::preadd_t  preadd_o
);
    import upsample_pkg::*;

    preadd_t preadd_q;
    preadd_t preadd_d;

    // Symmetric taps fold into one sum per coefficient
    // Lane i sits at window index i+3, its pair for tap j is x[k-j] + x[k+1+j]
    always_comb begin
        for (int i = 0; i < `UPS_LANES; i++) begin
            preadd_d.centre[i] = window_i.s[i+`UPS_LANES-1];
            for (int j = 0; j < 4; j++) begin
                preadd_d.pair[i][j] = pair_t'(window_i.s[i+3-j])
                                    + pair_t'(window_i.s[i+4+j]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            preadd_q <= '0;
        end else begin
            preadd_q <= preadd_d;
        end
    end

    assign preadd_o = preadd_q;

endmodule

// ==== src/sample_history.sv ====
`timescale 1ns/1ps
`include "upsample_macros.svh"

module sample_history (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  upsample_pkg::in_beat_t  data_i,
    output upsample_pkg::window_t   window_o
);
    import upsample_pkg::*;

    // Newest beat m+1, middle beat m, and the top three lanes of beat m-1
    in_beat_t newest_q;
    in_beat_t middle_q;
    logic [(`UPS_LANES-1)*`UPS_SAMPLE_W-1:0] tail_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            newest_q <= '0;
            middle_q <= '0;
            tail_q   <= '0;
        end else begin
            newest_q <= data_i;
            middle_q <= newest_q;
            // Lane 0 of the older beat is outside every filter span
            tail_q   <= middle_q[`UPS_SAMPLE_W +: (`UPS_LANES-1)*`UPS_SAMPLE_W];
        end
    end

    // Window index w maps to sample x[4m-3+w]
    always_comb begin
        for (int i = 0; i < `UPS_LANES-1; i++) begin
            window_o.s[i] = tail_q[i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W];
        end
        for (int i = 0; i < `UPS_LANES; i++) begin
            window_o.s[`UPS_LANES-1+i] = middle_q[i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W];
            window_o.s[2*`UPS_LANES-1+i] = newest_q[i*`UPS_SAMPLE_W +: `UPS_SAMPLE_W];
        end
    end

endmodule

// ==== src/upsample_pkg.sv ====
`include "upsample_macros.svh"

package upsample_pkg;

    // Scalar types
    typedef logic signed [`UPS_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`UPS_SAMPLE_W:0] pair_t;
    typedef logic signed [`UPS_COEFF_W-1:0] coeff_t;
    typedef logic signed [`UPS_SAMPLE_W+`UPS_COEFF_W:0] prod_t;
    typedef logic signed [`UPS_SAMPLE_W+`UPS_COEFF_W+3:0] acc_t;

    // Beats, lane 0 oldest in the low bits
    typedef logic [`UPS_LANES*`UPS_SAMPLE_W-1:0] in_beat_t;
    typedef logic [2*`UPS_LANES*`UPS_SAMPLE_W-1:0] out_beat_t;

    // Eleven samples x[4m-3] .. x[4m+7], index 0 is the oldest
    typedef struct packed {
        sample_t [3*`UPS_LANES-2:0] s;
    } window_t;

    // Pair sums indexed [lane][tap]
    typedef struct packed {
        sample_t [`UPS_LANES-1:0] centre;
        pair_t [`UPS_LANES-1:0][3:0] pair;
    } preadd_t;

    // Weighted pairs indexed [lane][tap]
    typedef struct packed {
        sample_t [`UPS_LANES-1:0] centre;
        prod_t [`UPS_LANES-1:0][3:0] prod;
    } product_t;

endpackage

// ==== src/upsample_macros.svh ====
`ifndef UPSAMPLE_MACROS_SVH
`define UPSAMPLE_MACROS_SVH

// Input samples per beat
`define UPS_LANES 4

// Sample and coefficient widths
`define UPS_SAMPLE_W 12
`define UPS_COEFF_W 16

// Coefficients are Q1.15
`define UPS_FRAC 15

// Half-band pair coefficients, centre outwards; they sum to 2**14
`define UPS_C0 (20070)
`define UPS_C1 (-5160)
`define UPS_C2 (1830)
`define UPS_C3 (-356)

`endif
